/* build.f */
+incdir+source
source/fixed_pkg.sv
source/vector_pkg.sv
source/vec_if.sv
source/norm_sq_stage.sv
source/inv_sqrt.sv
source/vec_scale_stage.sv
source/vec_normalize.sv
test/vec_normalize_chk.sv
test/norm_checker.sv
test/vec_normalize_tb.sv

/* source/common_defs.svh */
`ifndef COMMON_DEFS_SVH
`define COMMON_DEFS_SVH

// Q8.24 words: 8 integer bits, 24 fraction bits
`define FIX_W    32
`define FIX_FRAC 24

`endif

/* source/fixed_pkg.sv */
`default_nettype none
`include "common_defs.svh"

package fixed_pkg;

    localparam int FIX_W    = `FIX_W;
    localparam int FIX_FRAC = `FIX_FRAC;

    typedef logic [FIX_W-1:0] fix_t; // unsigned Q8.24

    // linear estimate of 1/sqrt(m) for m in [0.5, 1)
    localparam fix_t EST_C0 = 32'h016A09E6; // 1/sqrt(0.5)
    localparam fix_t EST_C1 = 32'h004CCCCC; // slope 0.3, about 11% off at both ends

    localparam fix_t THREE_HALVES = 32'h01800000;

    // 2^(-s/2), floor of the exact value
    localparam fix_t SCALE_TAB [16] = '{
        32'h01000000, 32'h00B504F3, 32'h00800000, 32'h005A8279,
        32'h00400000, 32'h002D413C, 32'h00200000, 32'h0016A09E,
        32'h00100000, 32'h000B504F, 32'h00080000, 32'h0005A827,
        32'h00040000, 32'h0002D413, 32'h00020000, 32'h00016A09
    };

    // 2^(s/2), top entries use all 8 integer bits
    localparam fix_t SCALE_UP_TAB [16] = '{
        32'h01000000, 32'h016A09E6, 32'h02000000, 32'h02D413CC,
        32'h04000000, 32'h05A82799, 32'h08000000, 32'h0B504F33,
        32'h10000000, 32'h16A09E66, 32'h20000000, 32'h2D413CCC,
        32'h40000000, 32'h5A827999, 32'h80000000, 32'hB504F333
    };

endpackage

`default_nettype wire

/* source/inv_sqrt.sv */
`timescale 1ns/10ps
`default_nettype none

module inv_sqrt #(
    parameter int DIM = vector_pkg::DIM_DEFAULT
) (
    input logic clk,
    input logic rst,
    vec_if.dst  i,
    vec_if.src  o
);

    localparam int FW   = fixed_pkg::FIX_W;
    localparam int FF   = fixed_pkg::FIX_FRAC;
    localparam int LAT  = vector_pkg::ISQ_LAT;
    localparam int NORM = FF - 1; // leading one lands here, m in [0.5, 1)

    logic [LAT-1:0]    vld;
    vector_pkg::comp_t vec_d [LAT][DIM];
    fixed_pkg::fix_t   len_d [LAT];
    logic [LAT-1:0]    degen_d;

    fixed_pkg::fix_t   m_next;
    fixed_pkg::fix_t   scale_next;
    fixed_pkg::fix_t   m_r [3];
    fixed_pkg::fix_t   scale_r [4];
    fixed_pkg::fix_t   y0;
    fixed_pkg::fix_t   y1;
    fixed_pkg::fix_t   y2;
    fixed_pkg::fix_t   inv_r;

    function automatic fixed_pkg::fix_t fmul(input fixed_pkg::fix_t a,
                                             input fixed_pkg::fix_t b);
        logic [2*FW-1:0] p;
        p = a * b;
        return p[FF +: FW];
    endfunction

    // y * (1.5 - (m/2)*y*y)
    function automatic fixed_pkg::fix_t newton(input fixed_pkg::fix_t y,
                                               input fixed_pkg::fix_t m);
        fixed_pkg::fix_t t;
        t = fmul(fmul(m >> 1, y), y);
        return fmul(y, fixed_pkg::THREE_HALVES - t);
    endfunction

    // priority encoder: find the leading one, pick shift and scale
    always_comb begin
        logic [$clog2(FW)-1:0] lead;
        logic [3:0]            sh;
        lead = '0;
        sh = '0;
        for (int b = 0; b < FW; b++) begin
            if (i.len_sq[b])
                lead = ($clog2(FW))'(b);
        end
        m_next = '0;
        scale_next = '0; // degenerate vectors end with inv_len of zero
        if (!i.degen) begin
            if (lead > NORM) begin
                sh = 4'(lead - NORM);
                m_next = i.len_sq >> sh;
                scale_next = fixed_pkg::SCALE_TAB[sh];
            end else begin
                sh = 4'(NORM - lead);
                m_next = i.len_sq << sh;
                scale_next = fixed_pkg::SCALE_UP_TAB[sh]; // entry 0 is 1.0
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst)
            vld <= '0;
        else
            vld <= {vld[LAT-2:0], i.valid};
    end

    always_ff @(posedge clk) begin
        if (i.valid) begin
            m_r[0]     <= m_next;
            scale_r[0] <= scale_next;
        end
        if (vld[0]) begin
            y0         <= fixed_pkg::EST_C0 - fmul(fixed_pkg::EST_C1, m_r[0]);
            m_r[1]     <= m_r[0];
            scale_r[1] <= scale_r[0];
        end
        if (vld[1]) begin
            y1         <= newton(y0, m_r[1]);
            m_r[2]     <= m_r[1];
            scale_r[2] <= scale_r[1];
        end
        if (vld[2]) begin
            y2         <= newton(y1, m_r[2]);
            scale_r[3] <= scale_r[2];
        end
        if (vld[3])
            inv_r <= fmul(y2, scale_r[3]); // undo the normalize shift
    end

    // vector and flags ride along
    always_ff @(posedge clk) begin
        if (i.valid) begin
            vec_d[0]   <= i.vec;
            len_d[0]   <= i.len_sq;
            degen_d[0] <= i.degen;
        end
        for (int s = 1; s < LAT; s++) begin
            if (vld[s-1]) begin
                vec_d[s]   <= vec_d[s-1];
                len_d[s]   <= len_d[s-1];
                degen_d[s] <= degen_d[s-1];
            end
        end
    end

    assign o.valid   = vld[LAT-1];
    assign o.vec     = vec_d[LAT-1];
    assign o.len_sq  = len_d[LAT-1];
    assign o.inv_len = inv_r;
    assign o.degen   = degen_d[LAT-1];

endmodule

`default_nettype wire

/* source/norm_sq_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module norm_sq_stage #(
    parameter int DIM = vector_pkg::DIM_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  vector_pkg::comp_t in_vec [DIM],
    vec_if.src                o
);

    localparam int FW = fixed_pkg::FIX_W;
    localparam int FF = fixed_pkg::FIX_FRAC;
    localparam int DEGEN_LSB = FF - 16; // len_sq below 2^-16 counts as zero

    logic              sq_valid;
    vector_pkg::comp_t vec_r   [DIM];
    fixed_pkg::fix_t   sq_r    [DIM];
    fixed_pkg::fix_t   sq_next [DIM];
    fixed_pkg::fix_t   sum;

    always_comb begin
        logic signed [2*FW-1:0] prod;
        for (int k = 0; k < DIM; k++) begin
            prod = in_vec[k] * in_vec[k];
            sq_next[k] = prod[FF +: FW]; // truncate back to Q8.24
        end
    end

    always_comb begin
        sum = '0;
        for (int k = 0; k < DIM; k++) begin
            sum = sum + sq_r[k];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            sq_valid <= 1'b0;
            o.valid  <= 1'b0;
        end else begin
            sq_valid <= in_valid;
            o.valid  <= sq_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            sq_r  <= sq_next;
            vec_r <= in_vec;
        end
        if (sq_valid) begin
            o.vec    <= vec_r;
            o.len_sq <= sum;
            o.degen  <= (sum[FW-1:DEGEN_LSB] == '0);
        end
    end

    assign o.inv_len = '0; // filled in by inv_sqrt

endmodule

`default_nettype wire

/* source/vec_if.sv */
`timescale 1ns/10ps
`default_nettype none

// one vector plus its length data, moving between pipeline stages
interface vec_if #(
    parameter int DIM = vector_pkg::DIM_DEFAULT
);

    logic              valid;   // one-cycle strobe
    vector_pkg::comp_t vec [DIM];
    fixed_pkg::fix_t   len_sq;
    fixed_pkg::fix_t   inv_len;
    logic              degen;

    modport src (output valid, vec, len_sq, inv_len, degen);
    modport dst (input valid, vec, len_sq, inv_len, degen);

endinterface

`default_nettype wire

/* source/vec_normalize.sv */
`timescale 1ns/10ps
`default_nettype none

module vec_normalize #(
    parameter int DIM = vector_pkg::DIM_DEFAULT
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         in_valid,
    input  logic [DIM*$bits(vector_pkg::comp_t)-1:0]     in_vec,
    output logic                                         out_valid,
    output logic [DIM*$bits(vector_pkg::comp_t)-1:0]     out_vec,
    output fixed_pkg::fix_t                              out_inv_len,
    output logic                                         out_degen
);

    localparam int CW = $bits(vector_pkg::comp_t);

    vector_pkg::comp_t in_arr  [DIM];
    vector_pkg::comp_t out_arr [DIM];

    if (DIM < 2 || DIM > 4) begin : g_dim_check
        $error("vec_normalize: DIM must be 2 to 4");
    end

    if (vector_pkg::SQ_LAT + vector_pkg::ISQ_LAT + vector_pkg::SCL_LAT
            != vector_pkg::TOTAL_LAT) begin : g_lat_check
        $error("vec_normalize: stage latencies do not add up to TOTAL_LAT");
    end

    // component 0 sits in the low word
    for (genvar k = 0; k < DIM; k++) begin : g_comp
        assign in_arr[k] = in_vec[k*CW +: CW];
        assign out_vec[k*CW +: CW] = out_arr[k];
    end

    vec_if #(.DIM(DIM)) sq_to_isq ();
    vec_if #(.DIM(DIM)) isq_to_scl ();

    norm_sq_stage #(.DIM(DIM)) u_norm_sq (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_vec   (in_arr),
        .o        (sq_to_isq.src)
    );

    inv_sqrt #(.DIM(DIM)) u_inv_sqrt (
        .clk (clk),
        .rst (rst),
        .i   (sq_to_isq.dst),
        .o   (isq_to_scl.src)
    );

    vec_scale_stage #(.DIM(DIM)) u_scale (
        .clk         (clk),
        .rst         (rst),
        .i           (isq_to_scl.dst),
        .out_valid   (out_valid),
        .out_vec     (out_arr),
        .out_inv_len (out_inv_len),
        .out_degen   (out_degen)
    );

endmodule

`default_nettype wire

/* source/vec_scale_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module vec_scale_stage #(
    parameter int DIM = vector_pkg::DIM_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,
    vec_if.dst                i,
    output logic              out_valid,
    output vector_pkg::comp_t out_vec [DIM],
    output fixed_pkg::fix_t   out_inv_len,
    output logic              out_degen
);

    localparam int FW = fixed_pkg::FIX_W;
    localparam int FF = fixed_pkg::FIX_FRAC;

    vector_pkg::comp_t scaled [DIM];

    always_comb begin
        logic signed [2*FW-1:0] prod;
        for (int k = 0; k < DIM; k++) begin
            // inv_len is unsigned and may use bit 31
            prod = i.vec[k] * $signed({1'b0, i.inv_len});
            scaled[k] = i.degen ? '0 : prod[FF +: FW];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst)
            out_valid <= 1'b0;
        else
            out_valid <= i.valid;
    end

    // outputs hold between strobes
    always_ff @(posedge clk) begin
        if (i.valid) begin
            out_vec     <= scaled;
            out_inv_len <= i.inv_len;
            out_degen   <= i.degen;
        end
    end

endmodule

`default_nettype wire

/* source/vector_pkg.sv */
`default_nettype none

package vector_pkg;

    // one signed Q8.24 component
    typedef logic signed [fixed_pkg::FIX_W-1:0] comp_t;

    localparam int DIM_DEFAULT = 3;

    // cycles from valid in to valid out, per stage
    localparam int SQ_LAT  = 2; // squares, then sum
    localparam int ISQ_LAT = 5; // normalize, estimate, two newton steps, rescale
    localparam int SCL_LAT = 1;

    localparam int TOTAL_LAT = 8;

endpackage

`default_nettype wire

/* test/norm_checker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "common_defs.svh"

module norm_checker #(
    parameter int DIM = vector_pkg::DIM_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [DIM*`FIX_W-1:0] in_vec,
    input  logic [127:0]          cur_name,
    input  logic [1:0]            cur_kind,
    input  logic                  out_valid,
    input  logic [DIM*`FIX_W-1:0] out_vec,
    input  logic [`FIX_W-1:0]     out_inv_len,
    input  logic                  out_degen,
    output int                    mismatches,
    output int                    other_errors,
    output int                    pending
);

    localparam int     W    = `FIX_W;
    localparam int     F    = `FIX_FRAC;
    localparam longint UNIT = 64'd1 << (2 * F); // 1.0 as a sum of raw squares
    localparam longint TOL  = 64'd1 << (2 * F - 8);
    localparam longint ONE  = 64'd1 << F;
    localparam longint ATOL = 64'd1 << (F - 10);

    typedef struct packed {
        logic [127:0]   name;
        logic [DIM*W-1:0] vec;
        logic [W-1:0]   inv;
        logic           degen;
        logic [1:0]     kind;
    } exp_t;

    exp_t exp_q [$];

    function automatic string text(input logic [127:0] name);
        string s;
        s = "";
        for (int b = 15; b >= 0; b--)
            if (name[b*8 +: 8] != 8'h00)
                s = {s, string'(name[b*8 +: 8])};
        return s;
    endfunction

    // unsigned Q8.24 product, truncated
    function automatic logic [W-1:0] umul(input logic [W-1:0] a, input logic [W-1:0] b);
        logic [2*W-1:0] p;
        p = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        return p[F +: W];
    endfunction

    function automatic logic [W-1:0] model_inv(input logic [W-1:0] len_sq);
        int p;
        logic [W-1:0] m;
        logic [W-1:0] scale;
        logic [W-1:0] y;
        p = -1;
        for (int b = W - 1; b >= 0; b--)
            if (p < 0 && len_sq[b])
                p = b;
        m = len_sq;
        scale = ONE[W-1:0];
        if (p > F - 1) begin
            m = len_sq >> (p - F + 1);
            scale = fixed_pkg::SCALE_TAB[p-F+1];
        end else if (p < F - 1) begin
            m = len_sq << (F - 1 - p);
            scale = fixed_pkg::SCALE_UP_TAB[F-1-p];
        end
        y = fixed_pkg::EST_C0 - umul(fixed_pkg::EST_C1, m);
        repeat (2)
            y = umul(y, fixed_pkg::THREE_HALVES - umul(umul(m >> 1, y), y));
        return umul(y, scale);
    endfunction

    task automatic push_expected();
        exp_t e;
        logic [W-1:0] len_sq;
        logic signed [2*W-1:0] c;
        logic signed [2*W-1:0] p;
        len_sq = '0;
        for (int k = 0; k < DIM; k++) begin
            c = {{W{in_vec[k*W+W-1]}}, in_vec[k*W +: W]};
            p = c * c;
            len_sq = len_sq + p[F +: W];
        end
        e.name = cur_name;
        e.kind = cur_kind;
        e.degen = (len_sq[W-1:F-16] == '0); // below 2^-16
        e.inv = e.degen ? '0 : model_inv(len_sq);
        for (int k = 0; k < DIM; k++) begin
            c = {{W{in_vec[k*W+W-1]}}, in_vec[k*W +: W]};
            p = c * $signed({{W{1'b0}}, e.inv});
            e.vec[k*W +: W] = e.degen ? '0 : p[F +: W];
        end
        exp_q.push_back(e);
    endtask

    task automatic check_output();
        exp_t e;
        longint c;
        longint sum;
        longint peak;
        if (exp_q.size() == 0) begin
            $display("out_valid seen at %0t with no vector outstanding", $time);
            other_errors++;
            return;
        end
        e = exp_q.pop_front();
        if (out_vec !== e.vec) begin
            $display("MISMATCH %s out_vec expected %h actual %h", text(e.name), e.vec, out_vec);
            mismatches++;
        end
        if (out_inv_len !== e.inv) begin
            $display("MISMATCH %s out_inv_len expected %h actual %h",
                     text(e.name), e.inv, out_inv_len);
            mismatches++;
        end
        if (out_degen !== e.degen) begin
            $display("MISMATCH %s out_degen expected %b actual %b",
                     text(e.name), e.degen, out_degen);
            mismatches++;
        end
        if (e.kind != 0) begin
            sum = 0;
            peak = 0;
            for (int k = 0; k < DIM; k++) begin
                c = longint'($signed(out_vec[k*W +: W]));
                sum += c * c;
                if (c < 0)
                    c = -c;
                if (c > peak)
                    peak = c;
            end
            if (sum > UNIT + TOL || sum < UNIT - TOL) begin
                $display("MISMATCH %s sum of squares expected %h +/- %h actual %h",
                         text(e.name), UNIT, TOL, sum);
                mismatches++;
            end
            if (e.kind == 2 && (peak > ONE + ATOL || peak < ONE - ATOL)) begin
                $display("MISMATCH %s axis component expected %h +/- %h actual %h",
                         text(e.name), ONE, ATOL, peak);
                mismatches++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            mismatches = 0;
            other_errors = 0;
            exp_q.delete();
        end else begin
            if (out_valid)
                check_output();
            if (in_valid)
                push_expected();
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

/* test/vec_normalize_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module vec_normalize_chk #(
    parameter int DIM = vector_pkg::DIM_DEFAULT
) (
    input logic                clk,
    input logic                rst,
    input logic                in_valid,
    input logic                out_valid,
    input logic [DIM*32-1:0]   out_vec,
    input logic                out_degen
);

    int fails = 0; // read by the testbench summary

    // each strobe comes out exactly TOTAL_LAT cycles later
    a_latency: assert property (@(posedge clk) disable iff (!rst)
        out_valid == $past(in_valid, vector_pkg::TOTAL_LAT))
    else begin
        $error("out_valid does not follow in_valid by the pipeline latency");
        fails++;
    end

    a_reset_low: assert property (@(posedge clk) !rst |=> !out_valid)
    else begin
        $error("out_valid high right after a reset cycle");
        fails++;
    end

    a_degen_zero: assert property (@(posedge clk) disable iff (!rst)
        out_valid && out_degen |-> out_vec == '0)
    else begin
        $error("degenerate vector with nonzero output components");
        fails++;
    end

endmodule

bind vec_normalize vec_normalize_chk #(.DIM(DIM)) u_chk (.*);

`default_nettype wire

/* test/vec_normalize_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module vec_normalize_tb;

    localparam int DIM = 3;
    localparam int W   = 32;

    typedef struct packed {
        logic [127:0]     name;
        logic [DIM*W-1:0] vec;   // component 0 in the low word
        logic [7:0]       rep;
        logic [7:0]       gap;   // idle cycles after the entry
        logic [1:0]       kind;  // 0 model only, 1 unit length, 2 unit axis
    } entry_t;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic [DIM*W-1:0] in_vec;
    logic             out_valid;
    logic [DIM*W-1:0] out_vec;
    logic [W-1:0]     out_inv_len;
    logic             out_degen;
    logic [127:0]     cur_name;
    logic [1:0]       cur_kind;
    int               mismatches;
    int               other_errors;
    int               pending;

    entry_t      tab [$];
    logic [31:0] rng = 32'h9de6;
    int          cycles = 0;
    int          limit = 0;

    vec_normalize #(.DIM(DIM)) u_dut (.*);

    norm_checker #(.DIM(DIM)) u_check (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // magnitude below 8.0
    function automatic logic [31:0] rand_comp();
        logic [31:0] mag;
        rng = xorshift32(rng);
        mag = {5'b0, rng[26:0]};
        return rng[31] ? -mag : mag;
    endfunction

    task automatic add_entry(input logic [127:0] name, input logic [31:0] x,
                             input logic [31:0] y, input logic [31:0] z,
                             input int rep, input int gap, input logic [1:0] kind);
        tab.push_back('{name, {z, y, x}, 8'(rep), 8'(gap), kind});
    endtask

    task automatic build_table();
        int gap;
        add_entry("axis_x", 32'h01000000, 0, 0, 2, 1, 2);
        add_entry("axis_neg_y", 0, 32'hFE000000, 0, 1, 0, 2); // -2.0
        add_entry("axis_z", 0, 0, 32'h00800000, 1, 2, 2);
        add_entry("axis_neg_x", 32'hF8800000, 0, 0, 1, 0, 2); // -7.5
        add_entry("zero", 0, 0, 0, 2, 1, 0);
        add_entry("tiny", 32'h00008000, 0, 0, 1, 0, 0);
        add_entry("tiny3", 32'h00008000, 32'h00008000, 32'h00008000, 1, 0, 0);
        add_entry("below_mix", 32'h0000B400, 32'h0000B400, 0, 1, 0, 0); // len_sq 252 lsb
        add_entry("above_mix", 32'h0000B600, 32'hFFFF4A00, 0, 1, 1, 0); // len_sq 258 lsb
        // leading one of len_sq at every bit from 8 to 29
        for (int k = 16; k <= 26; k++) begin
            add_entry("mag_even", 32'd1 << k, 0, 0, 1, 0, 0);
            add_entry("mag_odd", 0, 32'd3 << (k - 1), 0, 1, 0, 0);
        end
        add_entry("mag_p30", 32'h06000000, 32'h06000000, 0, 1, 0, 0);
        add_entry("mag_p31", 32'h07000000, 32'hF9000000, 32'h07000000, 1, 1, 0);
        repeat (40)
            add_entry("rand_b2b", rand_comp(), rand_comp(), rand_comp(), 1, 0, 1);
        repeat (12) begin
            rng = xorshift32(rng);
            gap = rng % 3;
            add_entry("rand_gap", rand_comp(), rand_comp(), rand_comp(), 1, gap, 1);
        end
    endtask

    task automatic finish_run(input logic timed_out);
        int asserts;
        asserts = u_dut.u_chk.fails;
        if (pending != 0)
            $display("run ended with %0d vectors never seen at the output", pending);
        $display("summary: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatches, other_errors, asserts);
        if (!timed_out && mismatches + other_errors + asserts + pending == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles waiting for the pipeline to drain", cycles);
            finish_run(1'b1);
        end
    end

    initial begin
        int total;
        rst = 1'b0;
        in_valid = 1'b0;
        in_vec = '0;
        cur_name = '0;
        cur_kind = '0;
        build_table();
        total = 0;
        foreach (tab[i])
            total += tab[i].rep + tab[i].gap;
        limit = 8 + total + vector_pkg::TOTAL_LAT + 20;
        repeat (8) @(posedge clk);
        #1 rst = 1'b1;
        foreach (tab[i]) begin
            for (int r = 0; r < tab[i].rep; r++) begin
                @(posedge clk);
                #1;
                in_valid = 1'b1;
                in_vec = tab[i].vec;
                cur_name = tab[i].name;
                cur_kind = tab[i].kind;
            end
            for (int g = 0; g < tab[i].gap; g++) begin
                @(posedge clk);
                #1 in_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1 in_valid = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (pending != 0);
        repeat (4) @(posedge clk); // a stray out_valid would show up here
        finish_run(1'b0);
    end

endmodule

`default_nettype wire
